//--- hw/cpu_ex_pkg.sv
package cpu_ex_pkg;

    localparam int REG_W      = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DIV_STEPS  = 32;
    localparam int DIV_CNT_W  = $clog2(DIV_STEPS);

    // multiply-accumulate progress carried through ex_mem
    localparam logic [1:0] CNT_IDLE  = 2'b00;
    localparam logic [1:0] CNT_FIRST = 2'b01;
    localparam logic [1:0] CNT_DONE  = 2'b10;

    typedef enum logic [5:0] {
        ALU_NOP   = 6'h00,
        ALU_OR    = 6'h01,
        ALU_AND   = 6'h02,
        ALU_XOR   = 6'h03,
        ALU_NOR   = 6'h04,
        ALU_SLL   = 6'h05,
        ALU_SRL   = 6'h06,
        ALU_SRA   = 6'h07,
        ALU_MOVN  = 6'h08,
        ALU_MOVZ  = 6'h09,
        ALU_MFHI  = 6'h0a,
        ALU_MFLO  = 6'h0b,
        ALU_ADD   = 6'h0c,
        ALU_ADDU  = 6'h0d,
        ALU_SUB   = 6'h0e,
        ALU_SUBU  = 6'h0f,
        ALU_MUL   = 6'h10,
        ALU_SLT   = 6'h11,
        ALU_SLTU  = 6'h12,
        ALU_CLZ   = 6'h13,
        ALU_CLO   = 6'h14,
        ALU_MTHI  = 6'h15,
        ALU_MTLO  = 6'h16,
        ALU_MULT  = 6'h17,
        ALU_MULTU = 6'h18,
        ALU_MADD  = 6'h19,
        ALU_MADDU = 6'h1a,
        ALU_MSUB  = 6'h1b,
        ALU_MSUBU = 6'h1c,
        ALU_DIV   = 6'h1d,
        ALU_DIVU  = 6'h1e,
        ALU_LDST  = 6'h1f
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'd0,
        SEL_LOGIC = 3'd1,
        SEL_SHIFT = 3'd2,
        SEL_MOVE  = 3'd3,
        SEL_ARITH = 3'd4,
        SEL_LDST  = 3'd5
    } alusel_e;

    typedef enum logic [1:0] {
        DIV_IDLE    = 2'd0,
        DIV_BY_ZERO = 2'd1,
        DIV_ON      = 2'd2,
        DIV_END     = 2'd3
    } div_state_e;

endpackage

//--- hw/div.sv
`timescale 1ns/10ps

module div (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               start_i,
    input  logic                               signed_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]       op1_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]       op2_i,
    output logic [2*cpu_ex_pkg::REG_W-1:0]     result_o,
    output logic                               ready_o
);
    import cpu_ex_pkg::*;

    div_state_e           state_q;
    logic [DIV_CNT_W-1:0] step_q;
    logic [REG_W-1:0]     divisor_q;
    logic [REG_W-1:0]     rem_q;
    logic [REG_W-1:0]     quo_q;
    logic                 neg_quo_q;
    logic                 neg_rem_q;
    logic [REG_W+1:0]     trial;
    logic [REG_W-1:0]     rem_nx;
    logic [REG_W-1:0]     quo_nx;

    // one restoring step shifts in the next dividend bit and tries the subtract
    assign trial = {1'b0, rem_q, quo_q[REG_W-1]} - {2'b00, divisor_q};

    always_comb begin
        if (!trial[REG_W+1]) begin
            rem_nx = trial[REG_W-1:0];
            quo_nx = {quo_q[REG_W-2:0], 1'b1};
        end else begin
            rem_nx = {rem_q[REG_W-2:0], quo_q[REG_W-1]};    // restore
            quo_nx = {quo_q[REG_W-2:0], 1'b0};
        end
    end

    assign ready_o = (state_q == DIV_END);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    step_q <= '0;
                    if (start_i)
                        state_q <= (op2_i == '0) ? DIV_BY_ZERO : DIV_ON;
                end
                DIV_BY_ZERO: state_q <= DIV_END;
                DIV_ON: begin
                    if (!start_i)
                        state_q <= DIV_IDLE;    // request withdrawn
                    else if (step_q == DIV_CNT_W'(DIV_STEPS - 1))
                        state_q <= DIV_END;
                    step_q <= step_q + 1'b1;
                end
                DIV_END: begin
                    if (!start_i)
                        state_q <= DIV_IDLE;
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            DIV_IDLE: begin
                rem_q     <= '0;
                quo_q     <= (signed_i && op1_i[REG_W-1]) ? -op1_i : op1_i;
                divisor_q <= (signed_i && op2_i[REG_W-1]) ? -op2_i : op2_i;
                neg_quo_q <= signed_i && (op1_i[REG_W-1] ^ op2_i[REG_W-1]);
                neg_rem_q <= signed_i && op1_i[REG_W-1];
            end
            DIV_BY_ZERO: result_o <= '0;
            DIV_ON: begin
                rem_q <= rem_nx;
                quo_q <= quo_nx;
                if (step_q == DIV_CNT_W'(DIV_STEPS - 1))
                    result_o <= {neg_rem_q ? -rem_nx : rem_nx,
                                 neg_quo_q ? -quo_nx : quo_nx};
            end
            default: ;    // result held while ready
        endcase
    end

endmodule

//--- hw/ex.sv
`timescale 1ns/10ps

module ex (
    input  cpu_ex_pkg::aluop_e                     aluop_i,
    input  cpu_ex_pkg::alusel_e                    alusel_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]           op1_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]           op2_i,
    input  logic [cpu_ex_pkg::REG_ADDR_W-1:0]      waddr_i,
    input  logic                                   reg_we_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]           hi_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]           lo_i,
    input  logic [1:0]                             cnt_i,
    input  logic [2*cpu_ex_pkg::REG_W-1:0]         hilo_temp_i,
    input  logic [2*cpu_ex_pkg::REG_W-1:0]         div_result_i,
    input  logic                                   div_ready_i,
    output logic [cpu_ex_pkg::REG_ADDR_W-1:0]      waddr_o,
    output logic                                   reg_we_o,
    output logic [cpu_ex_pkg::REG_W-1:0]           alu_res_o,
    output logic                                   hi_we_o,
    output logic                                   lo_we_o,
    output logic [cpu_ex_pkg::REG_W-1:0]           hi_o,
    output logic [cpu_ex_pkg::REG_W-1:0]           lo_o,
    output logic [1:0]                             cnt_o,
    output logic [2*cpu_ex_pkg::REG_W-1:0]         hilo_temp_o,
    output logic                                   div_start_o,
    output logic                                   div_signed_o,
    output logic [cpu_ex_pkg::REG_W-1:0]           div_op1_o,
    output logic [cpu_ex_pkg::REG_W-1:0]           div_op2_o,
    output logic                                   stallreq_o
);
    import cpu_ex_pkg::*;

    logic [REG_W-1:0]         logic_res;
    logic [REG_W-1:0]         shift_res;
    logic [REG_W-1:0]         move_res;
    logic [REG_W-1:0]         arith_res;
    logic [REG_W-1:0]         sum;
    logic [REG_W-1:0]         diff;
    logic [2*REG_W-1:0]       prod_s;
    logic [2*REG_W-1:0]       prod_u;
    logic [$clog2(REG_W)-1:0] shamt;
    logic                     ov;
    logic                     stall_acc;
    logic                     stall_div;

    // leading run of bit b counted from the msb
    function automatic logic [REG_W-1:0] count_lead(input logic [REG_W-1:0] val,
                                                     input logic b);
        logic [REG_W-1:0] n;
        logic             run;
        n   = '0;
        run = 1'b1;
        for (int i = REG_W - 1; i >= 0; i--) begin
            run = run & (val[i] == b);
            n   = n + run;
        end
        return n;
    endfunction

    assign sum    = op1_i + op2_i;
    assign diff   = op1_i - op2_i;
    assign prod_s = $signed(op1_i) * $signed(op2_i);
    assign prod_u = op1_i * op2_i;
    assign shamt  = op2_i[$clog2(REG_W)-1:0];

    assign div_signed_o = (aluop_i == ALU_DIV);
    assign div_op1_o    = op1_i;    // dividend
    assign div_op2_o    = op2_i;    // divisor
    assign stallreq_o   = stall_acc | stall_div;
    assign waddr_o      = waddr_i;

    always_comb begin
        logic_res = '0;
        shift_res = '0;
        move_res  = '0;
        arith_res = '0;
        ov        = 1'b0;
        reg_we_o  = reg_we_i;
        case (aluop_i)
            ALU_OR:   logic_res = op1_i | op2_i;
            ALU_AND:  logic_res = op1_i & op2_i;
            ALU_XOR:  logic_res = op1_i ^ op2_i;
            ALU_NOR:  logic_res = ~(op1_i | op2_i);
            ALU_SLL:  shift_res = op1_i << shamt;
            ALU_SRL:  shift_res = op1_i >> shamt;
            ALU_SRA:  shift_res = $signed(op1_i) >>> shamt;
            ALU_MOVN: begin
                move_res = op1_i;
                reg_we_o = reg_we_i & (op2_i != '0);    // only when rt nonzero
            end
            ALU_MOVZ: begin
                move_res = op1_i;
                reg_we_o = reg_we_i & (op2_i == '0);
            end
            ALU_MFHI: move_res = hi_i;
            ALU_MFLO: move_res = lo_i;
            ALU_ADD: begin
                arith_res = sum;
                ov = (~op1_i[REG_W-1] & ~op2_i[REG_W-1] & sum[REG_W-1]) |
                     (op1_i[REG_W-1] & op2_i[REG_W-1] & ~sum[REG_W-1]);
                reg_we_o = reg_we_i & ~ov;    // no write on signed overflow
            end
            ALU_ADDU: arith_res = sum;
            ALU_SUB: begin
                arith_res = diff;
                ov = (~op1_i[REG_W-1] & op2_i[REG_W-1] & diff[REG_W-1]) |
                     (op1_i[REG_W-1] & ~op2_i[REG_W-1] & ~diff[REG_W-1]);
                reg_we_o = reg_we_i & ~ov;
            end
            ALU_SUBU: arith_res = diff;
            ALU_MUL:  arith_res = prod_s[REG_W-1:0];
            ALU_SLT:  arith_res = {{(REG_W-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            ALU_SLTU: arith_res = {{(REG_W-1){1'b0}}, op1_i < op2_i};
            ALU_CLZ:  arith_res = count_lead(op1_i, 1'b0);
            ALU_CLO:  arith_res = count_lead(op1_i, 1'b1);
            default: ;
        endcase
    end

    always_comb begin
        case (alusel_i)
            SEL_LOGIC: alu_res_o = logic_res;
            SEL_SHIFT: alu_res_o = shift_res;
            SEL_MOVE:  alu_res_o = move_res;
            SEL_ARITH: alu_res_o = arith_res;
            SEL_LDST:  alu_res_o = sum;    // effective address
            default:   alu_res_o = '0;
        endcase
    end

    // HI/LO writes, accumulate sequence, divider request
    always_comb begin
        hi_we_o     = 1'b0;
        lo_we_o     = 1'b0;
        hi_o        = '0;
        lo_o        = '0;
        cnt_o       = CNT_IDLE;
        hilo_temp_o = '0;
        stall_acc   = 1'b0;
        stall_div   = 1'b0;
        div_start_o = 1'b0;
        case (aluop_i)
            ALU_MTHI: begin
                hi_we_o = 1'b1;
                hi_o    = op1_i;
            end
            ALU_MTLO: begin
                lo_we_o = 1'b1;
                lo_o    = op1_i;
            end
            ALU_MULT, ALU_MULTU: begin
                {hi_o, lo_o} = (aluop_i == ALU_MULT) ? prod_s : prod_u;
                hi_we_o      = 1'b1;
                lo_we_o      = 1'b1;
            end
            ALU_MADD, ALU_MADDU, ALU_MSUB, ALU_MSUBU: begin
                case (cnt_i)
                    CNT_IDLE: begin    // first cycle parks the product
                        hilo_temp_o = (aluop_i == ALU_MADD || aluop_i == ALU_MSUB) ?
                                      prod_s : prod_u;
                        cnt_o       = CNT_FIRST;
                        stall_acc   = 1'b1;
                    end
                    CNT_FIRST: begin
                        if (aluop_i == ALU_MADD || aluop_i == ALU_MADDU)
                            {hi_o, lo_o} = {hi_i, lo_i} + hilo_temp_i;
                        else
                            {hi_o, lo_o} = {hi_i, lo_i} - hilo_temp_i;
                        hi_we_o     = 1'b1;
                        lo_we_o     = 1'b1;
                        hilo_temp_o = hilo_temp_i;
                        cnt_o       = CNT_DONE;
                    end
                    default: cnt_o = CNT_DONE;    // already accumulated so no second add
                endcase
            end
            ALU_DIV, ALU_DIVU: begin
                if (div_ready_i) begin
                    {hi_o, lo_o} = div_result_i;    // hi = remainder, lo = quotient
                    hi_we_o      = 1'b1;
                    lo_we_o      = 1'b1;
                end else begin
                    div_start_o = 1'b1;
                    stall_div   = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- hw/ex_mem.sv
`timescale 1ns/10ps

module ex_mem (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                stall_i,
    input  logic [cpu_ex_pkg::REG_ADDR_W-1:0]   waddr_i,
    input  logic                                reg_we_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]        alu_res_i,
    input  logic                                hi_we_i,
    input  logic                                lo_we_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]        hi_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]        lo_i,
    input  logic [1:0]                          cnt_i,
    input  logic [2*cpu_ex_pkg::REG_W-1:0]      hilo_temp_i,
    output logic [cpu_ex_pkg::REG_ADDR_W-1:0]   mem_waddr_o,
    output logic                                mem_we_o,
    output logic [cpu_ex_pkg::REG_W-1:0]        mem_alu_res_o,
    output logic                                mem_hi_we_o,
    output logic                                mem_lo_we_o,
    output logic [cpu_ex_pkg::REG_W-1:0]        mem_hi_o,
    output logic [cpu_ex_pkg::REG_W-1:0]        mem_lo_o,
    output logic [1:0]                          cnt_o,
    output logic [2*cpu_ex_pkg::REG_W-1:0]      hilo_temp_o
);
    import cpu_ex_pkg::*;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_we_o    <= 1'b0;
            mem_hi_we_o <= 1'b0;
            mem_lo_we_o <= 1'b0;
            cnt_o       <= CNT_IDLE;
        end else if (stall_i) begin
            mem_we_o    <= 1'b0;    // bubble
            mem_hi_we_o <= 1'b0;
            mem_lo_we_o <= 1'b0;
            cnt_o       <= cnt_i;    // keep accumulate progress
        end else begin
            mem_we_o    <= reg_we_i;
            mem_hi_we_o <= hi_we_i;
            mem_lo_we_o <= lo_we_i;
            cnt_o       <= CNT_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        mem_waddr_o   <= waddr_i;
        mem_alu_res_o <= alu_res_i;
        mem_hi_o      <= hi_i;
        mem_lo_o      <= lo_i;
        hilo_temp_o   <= hilo_temp_i;    // partial product for the 2nd cycle
    end

endmodule

//--- hw/ex_unit_top.sv
`timescale 1ns/10ps

module ex_unit_top (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  cpu_ex_pkg::aluop_e                  aluop_i,
    input  cpu_ex_pkg::alusel_e                 alusel_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]        op1_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]        op2_i,
    input  logic [cpu_ex_pkg::REG_ADDR_W-1:0]   waddr_i,
    input  logic                                reg_we_i,
    output logic                                stall_o,
    output logic [cpu_ex_pkg::REG_ADDR_W-1:0]   mem_waddr_o,
    output logic                                mem_we_o,
    output logic [cpu_ex_pkg::REG_W-1:0]        mem_alu_res_o,
    output logic [cpu_ex_pkg::REG_W-1:0]        mem_hi_o,
    output logic [cpu_ex_pkg::REG_W-1:0]        mem_lo_o,
    output logic                                mem_hi_we_o,
    output logic                                mem_lo_we_o
);
    import cpu_ex_pkg::*;

    logic [REG_ADDR_W-1:0] ex_waddr;
    logic                  ex_reg_we;
    logic [REG_W-1:0]      ex_alu_res;
    logic                  ex_hi_we;
    logic                  ex_lo_we;
    logic [REG_W-1:0]      ex_hi;
    logic [REG_W-1:0]      ex_lo;
    logic [1:0]            ex_cnt;
    logic [1:0]            mem_cnt;
    logic [2*REG_W-1:0]    ex_hilo_temp;
    logic [2*REG_W-1:0]    mem_hilo_temp;
    logic [REG_W-1:0]      hi;
    logic [REG_W-1:0]      lo;
    logic                  div_start;
    logic                  div_signed;
    logic [REG_W-1:0]      div_op1;
    logic [REG_W-1:0]      div_op2;
    logic [2*REG_W-1:0]    div_result;
    logic                  div_ready;

    ex u_ex (
        .aluop_i(aluop_i), .alusel_i(alusel_i),
        .op1_i(op1_i), .op2_i(op2_i),
        .waddr_i(waddr_i), .reg_we_i(reg_we_i),
        .hi_i(hi), .lo_i(lo),
        .cnt_i(mem_cnt), .hilo_temp_i(mem_hilo_temp),
        .div_result_i(div_result), .div_ready_i(div_ready),
        .waddr_o(ex_waddr), .reg_we_o(ex_reg_we), .alu_res_o(ex_alu_res),
        .hi_we_o(ex_hi_we), .lo_we_o(ex_lo_we), .hi_o(ex_hi), .lo_o(ex_lo),
        .cnt_o(ex_cnt), .hilo_temp_o(ex_hilo_temp),
        .div_start_o(div_start), .div_signed_o(div_signed),
        .div_op1_o(div_op1), .div_op2_o(div_op2),
        .stallreq_o(stall_o)
    );

    div u_div (
        .clk_i(clk_i), .rst_i(rst_i),
        .start_i(div_start), .signed_i(div_signed),
        .op1_i(div_op1), .op2_i(div_op2),
        .result_o(div_result), .ready_o(div_ready)
    );

    ex_mem u_ex_mem (
        .clk_i(clk_i), .rst_i(rst_i), .stall_i(stall_o),
        .waddr_i(ex_waddr), .reg_we_i(ex_reg_we), .alu_res_i(ex_alu_res),
        .hi_we_i(ex_hi_we), .lo_we_i(ex_lo_we), .hi_i(ex_hi), .lo_i(ex_lo),
        .cnt_i(ex_cnt), .hilo_temp_i(ex_hilo_temp),
        .mem_waddr_o(mem_waddr_o), .mem_we_o(mem_we_o), .mem_alu_res_o(mem_alu_res_o),
        .mem_hi_we_o(mem_hi_we_o), .mem_lo_we_o(mem_lo_we_o),
        .mem_hi_o(mem_hi_o), .mem_lo_o(mem_lo_o),
        .cnt_o(mem_cnt), .hilo_temp_o(mem_hilo_temp)
    );

    // written one edge after ex_mem and bypassed back to ex
    hilo_reg u_hilo_reg (
        .clk_i(clk_i), .rst_i(rst_i),
        .hi_we_i(mem_hi_we_o), .lo_we_i(mem_lo_we_o),
        .hi_i(mem_hi_o), .lo_i(mem_lo_o),
        .hi_o(hi), .lo_o(lo)
    );

endmodule

//--- hw/hilo_reg.sv
`timescale 1ns/10ps

module hilo_reg (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            hi_we_i,
    input  logic                            lo_we_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]    hi_i,
    input  logic [cpu_ex_pkg::REG_W-1:0]    lo_i,
    output logic [cpu_ex_pkg::REG_W-1:0]    hi_o,
    output logic [cpu_ex_pkg::REG_W-1:0]    lo_o
);
    import cpu_ex_pkg::*;

    logic [REG_W-1:0] hi_q;
    logic [REG_W-1:0] lo_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (hi_we_i)
                hi_q <= hi_i;
            if (lo_we_i)
                lo_q <= lo_i;
        end
    end

    // pending write wins so the next op sees it
    assign hi_o = hi_we_i ? hi_i : hi_q;
    assign lo_o = lo_we_i ? lo_i : lo_q;

endmodule

//--- project.f
hw/cpu_ex_pkg.sv
hw/ex.sv
hw/div.sv
hw/hilo_reg.sv
hw/ex_mem.sv
hw/ex_unit_top.sv
sim/tb_ex_unit.sv

//--- sim/ex_unit_testdata.txt
// id aluop alusel op1 op2 waddr reg_we exp_we exp_res exp_hilo_we exp_hi exp_lo
// all hex, exp_hilo_we has hi_we in bit 1 and lo_we in bit 0
01 01 1 f0f01234 0f0f0000 01 1 1 ffff1234 0 00000000 00000000
02 02 1 ff00ff00 12345678 02 1 1 12005600 0 00000000 00000000
03 04 1 00000000 0000ffff 03 1 1 ffff0000 0 00000000 00000000
04 03 1 aaaa5555 ffff0000 04 1 1 55555555 0 00000000 00000000
05 05 2 00000001 0000001f 05 1 1 80000000 0 00000000 00000000
06 06 2 80000000 00000004 06 1 1 08000000 0 00000000 00000000
07 07 2 80000000 00000004 07 1 1 f8000000 0 00000000 00000000
08 11 4 ffffffff 00000001 08 1 1 00000001 0 00000000 00000000
09 12 4 ffffffff 00000001 09 1 1 00000000 0 00000000 00000000
0a 13 4 00010000 00000000 0a 1 1 0000000f 0 00000000 00000000
0b 14 4 fff00000 00000000 0b 1 1 0000000c 0 00000000 00000000
0c 10 4 fffffffd 00000007 0c 1 1 ffffffeb 0 00000000 00000000
0d 0c 4 7fffffff 00000001 0d 1 0 80000000 0 00000000 00000000
0e 0d 4 7fffffff 00000001 0e 1 1 80000000 0 00000000 00000000
0f 0e 4 80000000 00000001 0f 1 0 7fffffff 0 00000000 00000000
10 0f 4 80000000 00000001 10 1 1 7fffffff 0 00000000 00000000
11 0c 4 00000005 fffffffe 11 1 1 00000003 0 00000000 00000000
12 1f 5 00001000 fffffffc 12 1 1 00000ffc 0 00000000 00000000
13 09 3 12345678 00000000 13 1 1 12345678 0 00000000 00000000
14 08 3 12345678 00000000 14 1 0 12345678 0 00000000 00000000
15 15 0 deadbeef 00000000 00 0 0 00000000 2 deadbeef 00000000
16 0a 3 00000000 00000000 16 1 1 deadbeef 0 00000000 00000000
17 16 0 cafef00d 00000000 00 0 0 00000000 1 00000000 cafef00d
18 0b 3 00000000 00000000 18 1 1 cafef00d 0 00000000 00000000
19 17 0 fffffffe 00000003 00 0 0 00000000 3 ffffffff fffffffa
1a 19 0 00000004 00000005 00 0 0 00000000 3 00000000 0000000e
1b 1b 0 00000002 00000010 00 0 0 00000000 3 ffffffff ffffffee
1c 18 0 ffffffff 00000002 00 0 0 00000000 3 00000001 fffffffe
1d 1a 0 ffffffff ffffffff 00 0 0 00000000 3 ffffffff ffffffff
1e 1c 0 00000001 00000001 00 0 0 00000000 3 ffffffff fffffffe
1f 1d 0 fffffff9 00000002 00 0 0 00000000 3 ffffffff fffffffd
20 0b 3 00000000 00000000 1a 1 1 fffffffd 0 00000000 00000000
21 1e 0 00000064 00000007 00 0 0 00000000 3 00000002 0000000e
22 1d 0 00000007 fffffffe 00 0 0 00000000 3 00000001 fffffffd
23 1d 0 00000005 00000000 00 0 0 00000000 3 00000000 00000000
24 0a 3 00000000 00000000 1b 1 1 00000000 0 00000000 00000000

//--- sim/tb_ex_unit.sv
`timescale 1ns/10ps

module tb_ex_unit;
    import cpu_ex_pkg::*;

    localparam int CLK_PER = 20;
    localparam int RST_CYC = 8;
    localparam int FIELDS  = 12;    // words per vector line
    localparam int MAX_VEC = 64;

    logic                  clk_i;
    logic                  rst_i;
    aluop_e                aluop_i;
    alusel_e               alusel_i;
    logic [REG_W-1:0]      op1_i;
    logic [REG_W-1:0]      op2_i;
    logic [REG_ADDR_W-1:0] waddr_i;
    logic                  reg_we_i;
    logic                  stall_o;
    logic [REG_ADDR_W-1:0] mem_waddr_o;
    logic                  mem_we_o;
    logic [REG_W-1:0]      mem_alu_res_o;
    logic [REG_W-1:0]      mem_hi_o;
    logic [REG_W-1:0]      mem_lo_o;
    logic                  mem_hi_we_o;
    logic                  mem_lo_we_o;

    logic [31:0] vec_mem [0:MAX_VEC*FIELDS-1];
    int          num_vec;
    longint      limit_ns = 0;

    ex_unit_top dut0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .aluop_i(aluop_i), .alusel_i(alusel_i),
        .op1_i(op1_i), .op2_i(op2_i),
        .waddr_i(waddr_i), .reg_we_i(reg_we_i),
        .stall_o(stall_o),
        .mem_waddr_o(mem_waddr_o), .mem_we_o(mem_we_o), .mem_alu_res_o(mem_alu_res_o),
        .mem_hi_o(mem_hi_o), .mem_lo_o(mem_lo_o),
        .mem_hi_we_o(mem_hi_we_o), .mem_lo_we_o(mem_lo_we_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PER/2) clk_i = ~clk_i;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else fail_run($sformatf("[FAIL] %s %s expected %h actual %h", test, field, exp, act));
    endtask

    // accumulate ops hold the pipe for exactly one cycle and plain ops never
    function automatic int expected_stalls(input aluop_e op);
        case (op)
            ALU_MADD, ALU_MADDU, ALU_MSUB, ALU_MSUBU: return 1;
            default: return 0;
        endcase
    endfunction

    task automatic run_vector(input int idx);
        int    base;
        int    stalls;
        bit    is_div;
        string test;
        base     = idx * FIELDS;
        aluop_i  = aluop_e'(vec_mem[base+1][5:0]);
        alusel_i = alusel_e'(vec_mem[base+2][2:0]);
        op1_i    = vec_mem[base+3];
        op2_i    = vec_mem[base+4];
        waddr_i  = vec_mem[base+5][REG_ADDR_W-1:0];
        reg_we_i = vec_mem[base+6][0];
        test     = $sformatf("test %0d %s", vec_mem[base], aluop_i.name());
        is_div   = (aluop_i == ALU_DIV) || (aluop_i == ALU_DIVU);
        stalls   = 0;
        #(CLK_PER/4);    // sample away from both edges
        while (stall_o) begin    // inputs held meanwhile
            stalls++;
            @(negedge clk_i);
            #(CLK_PER/4);
        end
        @(negedge clk_i);    // result captured at the rising edge before
        if (is_div) begin
            assert (stalls > 0)
            else fail_run($sformatf("error: %s finished without stalling for the divider",
                                    test));
        end else begin
            check_field(test, "stall cycles", expected_stalls(aluop_i), stalls);
        end
        check_field(test, "mem_waddr", vec_mem[base+5], mem_waddr_o);
        check_field(test, "mem_we", vec_mem[base+7], mem_we_o);
        check_field(test, "mem_alu_res", vec_mem[base+8], mem_alu_res_o);
        check_field(test, "hi/lo we", vec_mem[base+9], {mem_hi_we_o, mem_lo_we_o});
        check_field(test, "mem_hi", vec_mem[base+10], mem_hi_o);
        check_field(test, "mem_lo", vec_mem[base+11], mem_lo_o);
    endtask

    // worst case every vector is a full divide
    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        fail_run($sformatf("error: run timed out after %0d ns before all vectors finished",
                           limit_ns));
    end

    initial begin
        rst_i    = 1'b1;
        aluop_i  = ALU_MULT;    // a write request that reset must block
        alusel_i = SEL_ARITH;
        op1_i    = 32'h0000_0003;
        op2_i    = 32'h0000_0005;
        waddr_i  = 5'd1;
        reg_we_i = 1'b1;
        $readmemh("sim/ex_unit_testdata.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && !$isunknown(vec_mem[num_vec*FIELDS]))
            num_vec++;
        if (num_vec == 0)
            fail_run("error: no vectors could be read from the test data file");
        limit_ns = longint'(num_vec * (DIV_STEPS + 4) + RST_CYC + 4) * CLK_PER;

        repeat (RST_CYC) @(posedge clk_i);
        @(negedge clk_i);
        check_field("reset", "mem_we", 0, mem_we_o);
        check_field("reset", "hi/lo we", 0, {mem_hi_we_o, mem_lo_we_o});
        aluop_i  = ALU_NOP;
        alusel_i = SEL_NOP;
        op1_i    = '0;
        op2_i    = '0;
        waddr_i  = '0;
        reg_we_i = 1'b0;
        rst_i    = 1'b0;
        @(negedge clk_i);    // first clock out of reset with nop inputs
        check_field("first clock", "mem_we", 0, mem_we_o);
        check_field("first clock", "hi/lo we", 0, {mem_hi_we_o, mem_lo_we_o});
        check_field("first clock", "stall", 0, stall_o);

        for (int i = 0; i < num_vec; i++)
            run_vector(i);

        $display("TEST PASSED");
        $finish;
    end

endmodule
